/* all.f */
+incdir+source
source/vga_timing_pkg.sv
source/vga_pixel_pkg.sv
source/vga_sync_gen.sv
source/bar_pattern_gen.sv
source/sprite_box_gen.sv
source/pixel_mixer.sv
source/vga_display_top.sv
dv/vga_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the vga display testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module vga_display_tb \
	-Mdir obj_dir -o vga_display_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/vga_display_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

/* dv/vga_display_tb.sv */
// testbench for the vga display top that checks raster timing, patterns, sprite overlay and blanking
`include "vga_params.svh"

module vga_display_tb
	import vga_timing_pkg::*;
	import vga_pixel_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 100;
	// two clks per pixel slot
	localparam int LINE_CLKS   = 2 * `VGA_H_TOTAL;
	localparam int FRAME_CLKS  = LINE_CLKS * `VGA_V_TOTAL;
	localparam int H_SYNC_CLKS = 2 * `VGA_H_SYNC;
	localparam int V_SYNC_CLKS = LINE_CLKS * `VGA_V_SYNC;
	localparam int NUM_ROWS    = 6;
	// two spare frames cover the reset and the partial frame at the end
	localparam int WATCHDOG_NS = (NUM_ROWS + 2) * FRAME_CLKS * CLK_PERIOD;

	// one frame of stimulus, hold_pos keeps the position moved in during the previous frame
	typedef struct packed {
		pattern_mode_e mode;
		rgb_t          solid;
		rgb_t          color;
		logic          hold_pos;
	} frame_row_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} sprite_pos_t;

	logic          clk;
	logic          rst;
	pattern_mode_e pattern_mode;
	rgb_t          solid_color;
	coord_t        sprite_x;
	coord_t        sprite_y;
	rgb_t          sprite_color;
	rgb_t          rgb;
	logic          hsync;
	logic          vsync;
	logic          de;

	frame_row_t  rows [NUM_ROWS];
	string       row_name [NUM_ROWS];
	// position latched for each frame and the one moved in halfway through it
	sprite_pos_t pos [NUM_ROWS];
	sprite_pos_t mid [NUM_ROWS];
	int          seed;

	// raster tracker state, all counted on falling edges
	int   clk_cnt;
	int   hs_rise_clk;
	int   vs_rise_clk;
	logic hs_seen;
	logic vs_seen;
	logic hs_q;
	logic vs_q;
	logic de_q;
	logic phase_locked;
	logic sample_parity;
	int   line_cnt;
	int   line_y;
	int   pix_x;
	logic frame_done;

	vga_display_top u_dut (
		.clk          (clk),
		.rst          (rst),
		.pattern_mode (pattern_mode),
		.solid_color  (solid_color),
		.sprite_x     (sprite_x),
		.sprite_y     (sprite_y),
		.sprite_color (sprite_color),
		.rgb          (rgb),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired before all frames were checked");
	end

	task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "colour check failed");
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %0d actual %0d", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "count check failed");
		end
	endtask

	function automatic int random_below(input int limit);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % limit;
	endfunction

	task automatic build_table();
		row_name[0] = "bars_sprite";
		rows[0]     = '{PAT_BARS, 12'h000, 12'h5A3, 1'b0};
		row_name[1] = "checker_latched";
		rows[1]     = '{PAT_CHECKER, 12'h000, 12'h3C9, 1'b1};
		row_name[2] = "solid_fill";
		rows[2]     = '{PAT_SOLID, 12'h48C, 12'hE21, 1'b0};
		row_name[3] = "pattern_off";
		rows[3]     = '{PAT_OFF, 12'h000, 12'h7F0, 1'b1};
		row_name[4] = "bars_latched";
		rows[4]     = '{PAT_BARS, 12'h000, 12'h123, 1'b1};
		row_name[5] = "solid_white";
		rows[5]     = '{PAT_SOLID, 12'hFFF, 12'h0F0, 1'b0};
		// positions stay clipped so the whole box is visible
		// the mid frame move always lands in the lower half that is still to be drawn
		for (int k = 0; k < NUM_ROWS; k++) begin
			if (rows[k].hold_pos && k > 0) begin
				pos[k] = mid[k - 1];
			end else begin
				pos[k].x = coord_t'(random_below(`VGA_H_ACTIVE - `VGA_SPRITE_W + 1));
				pos[k].y = coord_t'(random_below(`VGA_V_ACTIVE - `VGA_SPRITE_H + 1));
			end
			mid[k].x = coord_t'(random_below(`VGA_H_ACTIVE - `VGA_SPRITE_W + 1));
			mid[k].y = coord_t'(`VGA_V_ACTIVE / 2 +
				random_below(`VGA_V_ACTIVE / 2 - `VGA_SPRITE_H + 1));
		end
	endtask

	// a held row leaves the sprite inputs at the mid frame move of the row before
	task automatic apply_row(input int k);
		pattern_mode = rows[k].mode;
		solid_color  = rows[k].solid;
		sprite_color = rows[k].color;
		if (!rows[k].hold_pos) begin
			sprite_x = pos[k].x;
			sprite_y = pos[k].y;
		end
	endtask

	// expected colour of visible pixel px,py in frame k
	function automatic rgb_t expect_pixel(input int k, input int px, input int py);
		rgb_t bg;
		int   bar;
		int   sx;
		int   sy;
		bar = px / `VGA_BAR_WIDTH;
		case (rows[k].mode)
			PAT_BARS: begin
				bg.r = bar[2] ? 4'hF : 4'h0;
				bg.g = bar[1] ? 4'hF : 4'h0;
				bg.b = bar[0] ? 4'hF : 4'h0;
			end
			PAT_CHECKER: bg = ((((px ^ py) >> `VGA_CHECK_SHIFT) & 1) != 0) ? 12'hFFF : 12'h000;
			PAT_SOLID:   bg = rows[k].solid;
			default:     bg = 12'h000;
		endcase
		sx = int'(pos[k].x);
		sy = int'(pos[k].y);
		if (px >= sx && px < sx + `VGA_SPRITE_W && py >= sy && py < sy + `VGA_SPRITE_H) begin
			return rows[k].color;
		end
		return bg;
	endfunction

	// one falling edge of the tracker, outputs only move on rising edges so they are settled here
	task automatic watch_clock(input int k);
		clk_cnt = clk_cnt + 1;
		if (!de) begin
			check_rgb("blanking", rgb_t'('0), rgb);
		end
		if (hsync && !hs_q) begin
			if (hs_seen) begin
				check_count("hsync period", LINE_CLKS, clk_cnt - hs_rise_clk);
			end
			hs_rise_clk = clk_cnt;
			hs_seen     = 1'b1;
		end
		if (!hsync && hs_q) begin
			check_count("hsync width", H_SYNC_CLKS, clk_cnt - hs_rise_clk);
		end
		if (!vsync && vs_q) begin
			check_count("vsync width", V_SYNC_CLKS, clk_cnt - vs_rise_clk);
		end
		// the first de fixes which clk of each pair carries a new pixel
		if (de && !de_q) begin
			if (!phase_locked) begin
				phase_locked  = 1'b1;
				sample_parity = clk_cnt[0];
			end
			line_y   = line_cnt;
			line_cnt = line_cnt + 1;
			pix_x    = 0;
			// halfway down the frame the sprite moves, it must not show before the next frame
			if (line_y == `VGA_V_ACTIVE / 2) begin
				sprite_x = mid[k].x;
				sprite_y = mid[k].y;
			end
		end
		if (!de && de_q) begin
			check_count({row_name[k], " pixels per line"}, `VGA_H_ACTIVE, pix_x);
		end
		if (de && phase_locked && clk_cnt[0] == sample_parity) begin
			check_rgb(row_name[k], expect_pixel(k, pix_x, line_y), rgb);
			pix_x = pix_x + 1;
		end
		// vsync ends the visible frame, the next row goes in during vertical blanking
		if (vsync && !vs_q) begin
			if (vs_seen) begin
				check_count("vsync period", FRAME_CLKS, clk_cnt - vs_rise_clk);
			end
			vs_rise_clk = clk_cnt;
			vs_seen     = 1'b1;
			check_count({row_name[k], " lines per frame"}, `VGA_V_ACTIVE, line_cnt);
			line_cnt = 0;
			if (k + 1 < NUM_ROWS) begin
				apply_row(k + 1);
			end
			frame_done = 1'b1;
		end
		hs_q = hsync;
		vs_q = vsync;
		de_q = de;
	endtask

	initial begin
		seed          = 32'h07497410;
		rst           = 1'b1;
		pattern_mode  = PAT_OFF;
		solid_color   = '0;
		sprite_x      = '0;
		sprite_y      = '0;
		sprite_color  = '0;
		clk_cnt       = 0;
		hs_rise_clk   = 0;
		vs_rise_clk   = 0;
		hs_seen       = 1'b0;
		vs_seen       = 1'b0;
		hs_q          = 1'b0;
		vs_q          = 1'b0;
		de_q          = 1'b0;
		phase_locked  = 1'b0;
		sample_parity = 1'b0;
		line_cnt      = 0;
		line_y        = 0;
		pix_x         = 0;
		frame_done    = 1'b0;
		build_table();
		// the first frame starts right after reset, so its row goes in beforehand
		apply_row(0);
		repeat (4) @(negedge clk);
		rst = 1'b0;
		for (int k = 0; k < NUM_ROWS; k++) begin
			frame_done = 1'b0;
			while (!frame_done) begin
				@(negedge clk);
				watch_clock(k);
			end
		end
		$display("TEST OK");
		$finish;
	end

endmodule

/* source/vga_display_top.sv */
// vga display top that joins the sync generator, the two pixel sources and the mixer
module vga_display_top
	import vga_timing_pkg::*;
	import vga_pixel_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  pattern_mode_e pattern_mode,
	input  rgb_t          solid_color,
	input  coord_t        sprite_x,
	input  coord_t        sprite_y,
	input  rgb_t          sprite_color,
	output rgb_t          rgb,
	output logic          hsync,
	output logic          vsync,
	output logic          de
);

	// raster straight from the counters
	raster_t raster;
	// raster one slot later, aligned with both pixel source results
	raster_t bg_raster;
	rgb_t    bg_rgb;
	rgb_t    spr_rgb;
	logic    spr_hit;

	vga_sync_gen u_sync_gen (
		.clk    (clk),
		.rst    (rst),
		.raster (raster)
	);

	bar_pattern_gen u_bar_pattern_gen (
		.clk          (clk),
		.rst          (rst),
		.raster       (raster),
		.pattern_mode (pattern_mode),
		.solid_color  (solid_color),
		.bg_rgb       (bg_rgb),
		.bg_raster    (bg_raster)
	);

	// the sprite sees the same raster as the bar stage and loads on the same slots
	sprite_box_gen u_sprite_box_gen (
		.clk          (clk),
		.rst          (rst),
		.raster       (raster),
		.sprite_x     (sprite_x),
		.sprite_y     (sprite_y),
		.sprite_color (sprite_color),
		.spr_rgb      (spr_rgb),
		.spr_hit      (spr_hit)
	);

	pixel_mixer u_pixel_mixer (
		.clk       (clk),
		.rst       (rst),
		.bg_rgb    (bg_rgb),
		.spr_rgb   (spr_rgb),
		.bg_raster (bg_raster),
		.spr_hit   (spr_hit),
		.rgb       (rgb),
		.hsync     (hsync),
		.vsync     (vsync),
		.de        (de)
	);

endmodule

/* source/pixel_mixer.sv */
// pixel mixer that lays the sprite over the background, blanks and registers the vga outputs
module pixel_mixer
	import vga_timing_pkg::*;
	import vga_pixel_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  rgb_t    bg_rgb,
	input  rgb_t    spr_rgb,
	input  raster_t bg_raster,
	input  logic    spr_hit,
	output rgb_t    rgb,
	output logic    hsync,
	output logic    vsync,
	output logic    de
);

	rgb_t sel_rgb;
	rgb_t pix_next;

	// the sprite always wins where it is hit
	assign sel_rgb = spr_hit ? spr_rgb : bg_rgb;

	// monitors expect black in the porches and sync, otherwise they
	// take the blanking level wrong and the picture looks washed out
	assign pix_next = bg_raster.active ? sel_rgb : rgb_t'('0);

	// the pixel sources both loaded on the previous slot,
	// so their results are stable by the time this slot comes round
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb   <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			de    <= 1'b0;
		end else if (bg_raster.px_en) begin
			rgb   <= pix_next;
			// syncs get the same two slot delay as the colour
			hsync <= bg_raster.hsync;
			vsync <= bg_raster.vsync;
			de    <= bg_raster.active;
		end
	end

	// no colour ever leaks outside the visible area
	a_blank: assert property (@(posedge clk) disable iff (rst)
		!de |-> (rgb == rgb_t'('0)));

endmodule

/* source/sprite_box_gen.sv */
// sprite generator that draws one solid rectangle latched at each frame start
`include "vga_params.svh"

module sprite_box_gen
	import vga_timing_pkg::*;
	import vga_pixel_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  raster_t raster,
	input  coord_t  sprite_x,
	input  coord_t  sprite_y,
	input  rgb_t    sprite_color,
	output rgb_t    spr_rgb,
	output logic    spr_hit
);

	coord_t lat_x;
	coord_t lat_y;
	rgb_t   lat_color;
	coord_t cur_x;
	coord_t cur_y;
	rgb_t   cur_color;
	coord_t dx;
	coord_t dy;
	logic   latch_now;
	logic   hit_x;
	logic   hit_y;

	// host inputs are sampled once per frame so the box never tears mid frame
	assign latch_now = raster.px_en & raster.frame_start;

	// pixel 0,0 already has to use the values being latched in its own slot
	assign cur_x     = latch_now ? sprite_x : lat_x;
	assign cur_y     = latch_now ? sprite_y : lat_y;
	assign cur_color = latch_now ? sprite_color : lat_color;

	// offset into the box, the lower bound check keeps a wrapped difference out
	assign dx    = raster.x - cur_x;
	assign dy    = raster.y - cur_y;
	assign hit_x = (raster.x >= cur_x) && (dx < coord_t'(`VGA_SPRITE_W));
	assign hit_y = (raster.y >= cur_y) && (dy < coord_t'(`VGA_SPRITE_H));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lat_x   <= '0;
			lat_y   <= '0;
			spr_hit <= 1'b0;
		end else begin
			if (latch_now) begin
				lat_x <= sprite_x;
				lat_y <= sprite_y;
			end
			// hit lines up with the background colour of the same slot
			if (raster.px_en) begin
				spr_hit <= hit_x & hit_y;
			end
		end
	end

	// sprite colour is latched with the position and copied out on every slot
	always_ff @(posedge clk) begin
		if (latch_now) begin
			lat_color <= sprite_color;
		end
		if (raster.px_en) begin
			spr_rgb <= cur_color;
		end
	end

	// the latched position may only move in the slot of pixel 0,0
	a_pos_hold: assert property (@(posedge clk) disable iff (rst)
		!(raster.px_en && (raster.x == '0) && (raster.y == '0)) |=>
		$stable(lat_x) && $stable(lat_y));

endmodule

/* source/bar_pattern_gen.sv */
// background pattern generator for colour bars, checkerboard or a solid colour
`include "vga_params.svh"

module bar_pattern_gen
	import vga_timing_pkg::*;
	import vga_pixel_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  raster_t       raster,
	input  pattern_mode_e pattern_mode,
	input  rgb_t          solid_color,
	output rgb_t          bg_rgb,
	output raster_t       bg_raster
);

	// bar n lights red for bit 2, green for bit 1 and blue for bit 0
	localparam rgb_t BAR_TABLE [8] = '{
		12'h000, 12'h00F, 12'h0F0, 12'h0FF,
		12'hF00, 12'hF0F, 12'hFF0, 12'hFFF
	};

	coord_t bar_num;
	logic   check_odd;
	rgb_t   bg_next;
	logic   en_d1;

	// past column 639 the index runs beyond 7 but those pixels are blanked later
	assign bar_num   = raster.x / coord_t'(`VGA_BAR_WIDTH);
	assign check_odd = raster.x[`VGA_CHECK_SHIFT] ^ raster.y[`VGA_CHECK_SHIFT];

	always_comb begin
		case (pattern_mode)
			PAT_BARS:    bg_next = BAR_TABLE[bar_num[2:0]];
			PAT_CHECKER: bg_next = check_odd ? rgb_t'('1) : rgb_t'('0);
			PAT_SOLID:   bg_next = solid_color;
			default:     bg_next = '0;
		endcase
	end

	// the delayed raster keeps its own slot enable two clks behind the source,
	// same phase as the sync generator so the mixer loads on the next slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			en_d1     <= 1'b0;
			bg_raster <= '0;
		end else begin
			en_d1 <= raster.px_en;
			if (raster.px_en) begin
				bg_raster <= raster;
			end
			// overrides the px_en field copied above
			bg_raster.px_en <= en_d1;
		end
	end

	// colour only ever moves together with the raster fields loaded above
	always_ff @(posedge clk) begin
		if (raster.px_en) begin
			bg_rgb <= bg_next;
		end
	end

endmodule

/* source/vga_sync_gen.sv */
// vga sync generator that paces pixel slots, counts column and row and decodes sync windows
`include "vga_params.svh"

module vga_sync_gen
	import vga_timing_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	output raster_t raster
);

	localparam int H_TOTAL      = `VGA_H_TOTAL;
	localparam int V_TOTAL      = `VGA_V_TOTAL;
	// sync windows start after the visible part and the front porch
	localparam int H_SYNC_START = `VGA_H_ACTIVE + `VGA_H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + `VGA_H_SYNC;
	localparam int V_SYNC_START = `VGA_V_ACTIVE + `VGA_V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + `VGA_V_SYNC;

	coord_t  x_next;
	coord_t  y_next;
	logic    line_end;
	logic    frame_end;
	raster_t raster_next;

	assign line_end  = (raster.x == coord_t'(H_TOTAL - 1));
	assign frame_end = (raster.y == coord_t'(V_TOTAL - 1));

	// the counters step at the end of each pixel slot
	// so in the idle clk between slots they already hold the next pixel
	always_comb begin
		x_next = raster.x;
		y_next = raster.y;
		if (raster.px_en) begin
			if (line_end) begin
				x_next = '0;
				// row moves on only when the column wraps
				if (frame_end) begin
					y_next = '0;
				end else begin
					y_next = raster.y + 1'b1;
				end
			end else begin
				x_next = raster.x + 1'b1;
			end
		end
	end

	// everything is decoded from the next counter values and registered with them,
	// that way the flags always describe the same pixel as x and y
	always_comb begin
		// the 50 MHz clk is halved by simply toggling the slot enable
		raster_next.px_en       = ~raster.px_en;
		raster_next.x           = x_next;
		raster_next.y           = y_next;
		raster_next.active      = (x_next < coord_t'(`VGA_H_ACTIVE)) &&
		                          (y_next < coord_t'(`VGA_V_ACTIVE));
		raster_next.hsync       = (x_next >= coord_t'(H_SYNC_START)) &&
		                          (x_next < coord_t'(H_SYNC_END));
		raster_next.vsync       = (y_next >= coord_t'(V_SYNC_START)) &&
		                          (y_next < coord_t'(V_SYNC_END));
		// only flag the slot itself and not the idle clk in front of it
		raster_next.frame_start = ~raster.px_en && (x_next == '0) && (y_next == '0);
	end

	// after reset the first slot comes one clk later and shows pixel 0,0
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			raster <= '0;
		end else begin
			raster <= raster_next;
		end
	end

	// column stays inside the 800 slot line
	a_x_range: assert property (@(posedge clk) disable iff (rst)
		raster.x <= coord_t'(H_TOTAL - 1));

	// row stays inside the 525 line frame
	a_y_range: assert property (@(posedge clk) disable iff (rst)
		raster.y <= coord_t'(V_TOTAL - 1));

	// slots never come back to back, downstream stages rely on the idle clk
	a_px_en_gap: assert property (@(posedge clk) disable iff (rst)
		raster.px_en |=> !raster.px_en);

endmodule

/* source/vga_pixel_pkg.sv */
// colour and background pattern selection types for the vga pixel sources and mixer
package vga_pixel_pkg;

	// one colour channel, the DAC takes four bits per channel
	typedef logic [3:0] chan_t;

	// a 12 bit pixel colour
	// r sits in the top nibble so a hex literal reads as 12'hRGB
	typedef struct packed {
		chan_t r;
		chan_t g;
		chan_t b;
	} rgb_t;

	// background pattern chosen by the host
	typedef enum logic [1:0] {
		// eight vertical colour bars, black on the left and white on the right
		PAT_BARS    = 2'd0,
		// black and white squares
		PAT_CHECKER = 2'd1,
		// the whole screen in solid_color
		PAT_SOLID   = 2'd2,
		// background off, only the sprite shows
		PAT_OFF     = 2'd3
	} pattern_mode_e;

endpackage

/* source/vga_timing_pkg.sv */
// raster position and timing types passed from the sync generator down the pixel pipeline
package vga_timing_pkg;

	// a column or row index, wide enough for the 800 slot line and the 525 line frame
	typedef logic [9:0] coord_t;

	// one pixel slot of the raster as seen by every stage
	// px_en marks the clk on which a stage may load, the other fields
	// only mean something while it is high
	typedef struct packed {
		// this clk is a pixel slot
		logic   px_en;
		// current column and row
		coord_t x;
		coord_t y;
		// inside the 640x480 visible area
		logic   active;
		// sync windows, active high
		logic   hsync;
		logic   vsync;
		// first slot of pixel 0,0 so a new frame begins here
		logic   frame_start;
	} raster_t;

endpackage

/* source/vga_params.svh */
// vga raster timing, background pattern geometry and sprite size for 640x480 at 25 MHz
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// horizontal timing in pixel slots, visible part first and then front porch, sync, back porch
`define VGA_H_ACTIVE 640
`define VGA_H_FRONT  16
`define VGA_H_SYNC   96
`define VGA_H_BACK   48

// vertical timing counted in whole lines
`define VGA_V_ACTIVE 480
`define VGA_V_FRONT  10
`define VGA_V_SYNC   2
`define VGA_V_BACK   33

// full line and frame lengths, 800 slots and 525 lines for this mode
`define VGA_H_TOTAL (`VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK)
`define VGA_V_TOTAL (`VGA_V_ACTIVE + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK)

// eight colour bars share the visible line evenly
`define VGA_BAR_WIDTH 80

// checker squares are 2**shift pixels on a side
// the square parity is read straight from this bit of x and y
`define VGA_CHECK_SHIFT 5

// sprite rectangle size in pixels
`define VGA_SPRITE_W 32
`define VGA_SPRITE_H 32

`endif
